// File: src/bramArrayPkg.sv
// Geometry of the dual-port block-RAM array
// Three 32-bit cells side by side and four cells deep give 4096 words of 96 bits.
// Also holds the word-address view that is shared by the decoder and the top level
package bramArrayPkg;

  // One behavioral cell
  localparam int BramBitw     = 32;
  localparam int BramBytew    = BramBitw / 8;
  localparam int NumBramWords = 1024;

  // Grid of cells
  localparam int NumParBrams = 3;
  localparam int NumSerBrams = 4;

  // Resulting array
  localparam int ArrBitw     = BramBitw * NumParBrams;
  localparam int ArrBytew    = BramBytew * NumParBrams;
  localparam int NumArrWords = NumBramWords * NumSerBrams;

  // Byte addressing, the low bits pick a byte inside one 12-byte word
  localparam int AddrBitw     = 32;
  localparam int AddrWordBito = $clog2(ArrBytew);

  localparam int WordAddrBitw = $clog2(NumArrWords);
  localparam int SerIdxBitw   = $clog2(NumSerBrams);
  localparam int WordIdxBitw  = $clog2(NumBramWords);

  // Split view of a word address, row on top
  typedef struct packed {
    logic [SerIdxBitw-1:0]  serIdx;
    logic [WordIdxBitw-1:0] wordIdx;
  } wordAddrSplitT;

  // Same word address seen as one number or as row and word index
  typedef union packed {
    logic [WordAddrBitw-1:0] flat;
    wordAddrSplitT           split;
  } wordAddrT;

endpackage

// File: src/bramAddrDecode.sv
// Address decoder for one port of the block-RAM array
// Splits a byte address into the row of cells and the word inside a cell,
// and flags addresses beyond the array so that their writes can be dropped
`timescale 1ns/1ps

module bramAddrDecode
  import bramArrayPkg::*;
(
  input  logic                   A_PS,
  input  logic                   rst,
  input  logic                   en,
  input  logic [AddrBitw-1:0]    addr,
  output logic [SerIdxBitw-1:0]  rowIdx,
  output logic [WordIdxBitw-1:0] wordIdx,
  output logic                   outOfRange
);

  wordAddrT wordAddr;

  // Word field sits right above the byte offset
  assign wordAddr.flat = addr[AddrWordBito +: WordAddrBitw];

  // Anything set above the word field lies outside the array
  assign outOfRange = |addr[AddrBitw-1:AddrWordBito+WordAddrBitw];

  // Out-of-range reads fall back to row 0
  assign rowIdx  = outOfRange ? '0 : wordAddr.split.serIdx;
  assign wordIdx = wordAddr.split.wordIdx;

  // Byte addressing is for bus compatibility only, accesses must be word aligned
  assertAligned: assert property (
    @(posedge A_PS) disable iff (rst)
    en |-> (addr[AddrWordBito-1:0] == '0)
  ) else $error("Unaligned access at address %h", addr);

endmodule

// File: src/bramCell.sv
// Behavioral true dual-port RAM cell, 32 bits by 1024 words
// Byte-wise writes on both ports, write-first read data,
// output registers cleared by reset
`timescale 1ns/1ps

module bramCell
  import bramArrayPkg::*;
(
  input  logic                   A_PS,
  input  logic                   rst,

  input  logic                   aEn,
  input  logic [WordIdxBitw-1:0] aWordIdx,
  input  logic [BramBytew-1:0]   aWe,
  input  logic [BramBitw-1:0]    aWrData,
  output logic [BramBitw-1:0]    aRdData,

  input  logic                   bEn,
  input  logic [WordIdxBitw-1:0] bWordIdx,
  input  logic [BramBytew-1:0]   bWe,
  input  logic [BramBitw-1:0]    bWrData,
  output logic [BramBitw-1:0]    bRdData
);

  logic [BramBitw-1:0] mem [NumBramWords];

  // Stored word with this port's enabled bytes already merged in
  logic [BramBitw-1:0] aMerged;
  logic [BramBitw-1:0] bMerged;

  always_comb begin
    aMerged = mem[aWordIdx];
    bMerged = mem[bWordIdx];
    for (int i = 0; i < BramBytew; i++) begin
      if (aWe[i]) begin
        aMerged[i*8 +: 8] = aWrData[i*8 +: 8];
      end
      if (bWe[i]) begin
        bMerged[i*8 +: 8] = bWrData[i*8 +: 8];
      end
    end
  end

  // Byte lanes are written one by one so that both ports may share a word
  always_ff @(posedge A_PS) begin
    for (int i = 0; i < BramBytew; i++) begin
      if (aEn && aWe[i]) begin
        mem[aWordIdx][i*8 +: 8] <= aWrData[i*8 +: 8];
      end
      if (bEn && bWe[i]) begin
        mem[bWordIdx][i*8 +: 8] <= bWrData[i*8 +: 8];
      end
    end
  end

  // Write-first outputs, held while the port is idle
  always_ff @(posedge A_PS) begin
    if (rst) begin
      aRdData <= '0;
      bRdData <= '0;
    end else begin
      if (aEn) begin
        aRdData <= aMerged;
      end
      if (bEn) begin
        bRdData <= bMerged;
      end
    end
  end

  // Both ports hitting the same bytes of one word in one cycle is not allowed
  assertNoCollision: assert property (
    @(posedge A_PS) disable iff (rst)
    !(aEn && bEn && (aWordIdx == bWordIdx) && |(aWe & bWe))
  ) else $error("Write collision on word %0d", aWordIdx);

endmodule

// File: src/bramCellArray.sv
// Grid of dual-port RAM cells, NumParBrams wide and NumSerBrams deep
// Each port's byte enables reach only the addressed row,
// and every row returns its read word to both ports
`timescale 1ns/1ps

module bramCellArray
  import bramArrayPkg::*;
(
  input  logic                                  A_PS,
  input  logic                                  rst,

  input  logic                                  aEn,
  input  logic [SerIdxBitw-1:0]                 aRowIdx,
  input  logic [WordIdxBitw-1:0]                aWordIdx,
  input  logic                                  aOutOfRange,
  input  logic [ArrBytew-1:0]                   aWrEn,
  input  logic [ArrBitw-1:0]                    aWrData,

  input  logic                                  bEn,
  input  logic [SerIdxBitw-1:0]                 bRowIdx,
  input  logic [WordIdxBitw-1:0]                bWordIdx,
  input  logic                                  bOutOfRange,
  input  logic [ArrBytew-1:0]                   bWrEn,
  input  logic [ArrBitw-1:0]                    bWrData,

  output logic [NumSerBrams-1:0][ArrBitw-1:0]   aRowData,
  output logic [NumSerBrams-1:0][ArrBitw-1:0]   bRowData
);

  for (genvar s = 0; s < NumSerBrams; s++) begin : genRow

    logic [ArrBytew-1:0] aRowWe;
    logic [ArrBytew-1:0] bRowWe;

    // Out-of-range addresses write nowhere
    assign aRowWe = (aRowIdx == SerIdxBitw'(s) && !aOutOfRange) ? aWrEn : '0;
    assign bRowWe = (bRowIdx == SerIdxBitw'(s) && !bOutOfRange) ? bWrEn : '0;

    for (genvar p = 0; p < NumParBrams; p++) begin : genCol
      bramCell bramCell_inst (
        .A_PS     (A_PS),
        .rst      (rst),
        .aEn      (aEn),
        .aWordIdx (aWordIdx),
        .aWe      (aRowWe[p*BramBytew +: BramBytew]),
        .aWrData  (aWrData[p*BramBitw +: BramBitw]),
        .aRdData  (aRowData[s][p*BramBitw +: BramBitw]),
        .bEn      (bEn),
        .bWordIdx (bWordIdx),
        .bWe      (bRowWe[p*BramBytew +: BramBytew]),
        .bWrData  (bWrData[p*BramBitw +: BramBitw]),
        .bRdData  (bRowData[s][p*BramBitw +: BramBitw])
      );
    end

  end

endmodule

// File: src/bramReadSelect.sv
// Read data selector for one port
// Remembers which row was accessed and picks that row's word
// once the cells have their output ready
`timescale 1ns/1ps

module bramReadSelect
  import bramArrayPkg::*;
(
  input  logic                                A_PS,
  input  logic                                rst,
  input  logic                                en,
  input  logic [SerIdxBitw-1:0]               rowIdx,
  input  logic [NumSerBrams-1:0][ArrBitw-1:0] rowData,
  output logic [ArrBitw-1:0]                  rdData
);

  logic [SerIdxBitw-1:0] rowIdxQ;

  // Loads on the same edge as the cell output registers
  always_ff @(posedge A_PS) begin
    if (rst) begin
      rowIdxQ <= '0;
    end else if (en) begin
      rowIdxQ <= rowIdx;
    end
  end

  assign rdData = rowData[rowIdxQ];

endmodule

// File: src/tdpBramArray.sv
// True dual-port block-RAM array, 4096 words of 96 bits
// Byte-addressed ports A and B share one clock and one reset,
// read data follows an enabled access by one cycle
`timescale 1ns/1ps

module tdpBramArray
  import bramArrayPkg::*;
(
  input  logic                A_PS,
  input  logic                rst,

  input  logic                aEn,
  input  logic [AddrBitw-1:0] aAddr,
  input  logic [ArrBytew-1:0] aWrEn,
  input  logic [ArrBitw-1:0]  aWrData,
  output logic [ArrBitw-1:0]  aRdData,

  input  logic                bEn,
  input  logic [AddrBitw-1:0] bAddr,
  input  logic [ArrBytew-1:0] bWrEn,
  input  logic [ArrBitw-1:0]  bWrData,
  output logic [ArrBitw-1:0]  bRdData
);

  // Decoded word address per port
  wordAddrT aWordAddr;
  wordAddrT bWordAddr;
  logic     aOutOfRange;
  logic     bOutOfRange;

  logic [NumSerBrams-1:0][ArrBitw-1:0] aRowData;
  logic [NumSerBrams-1:0][ArrBitw-1:0] bRowData;

  bramAddrDecode aDecode_inst (
    .A_PS       (A_PS),
    .rst        (rst),
    .en         (aEn),
    .addr       (aAddr),
    .rowIdx     (aWordAddr.split.serIdx),
    .wordIdx    (aWordAddr.split.wordIdx),
    .outOfRange (aOutOfRange)
  );

  bramAddrDecode bDecode_inst (
    .A_PS       (A_PS),
    .rst        (rst),
    .en         (bEn),
    .addr       (bAddr),
    .rowIdx     (bWordAddr.split.serIdx),
    .wordIdx    (bWordAddr.split.wordIdx),
    .outOfRange (bOutOfRange)
  );

  bramCellArray bramCellArray_inst (
    .A_PS        (A_PS),
    .rst         (rst),
    .aEn         (aEn),
    .aRowIdx     (aWordAddr.split.serIdx),
    .aWordIdx    (aWordAddr.split.wordIdx),
    .aOutOfRange (aOutOfRange),
    .aWrEn       (aWrEn),
    .aWrData     (aWrData),
    .bEn         (bEn),
    .bRowIdx     (bWordAddr.split.serIdx),
    .bWordIdx    (bWordAddr.split.wordIdx),
    .bOutOfRange (bOutOfRange),
    .bWrEn       (bWrEn),
    .bWrData     (bWrData),
    .aRowData    (aRowData),
    .bRowData    (bRowData)
  );

  bramReadSelect aReadSelect_inst (
    .A_PS    (A_PS),
    .rst     (rst),
    .en      (aEn),
    .rowIdx  (aWordAddr.split.serIdx),
    .rowData (aRowData),
    .rdData  (aRdData)
  );

  bramReadSelect bReadSelect_inst (
    .A_PS    (A_PS),
    .rst     (rst),
    .en      (bEn),
    .rowIdx  (bWordAddr.split.serIdx),
    .rowData (bRowData),
    .rdData  (bRdData)
  );

endmodule

// File: tb/tdpBramArrayTb.sv
// Directed testbench for the true dual-port block-RAM array
// Keeps a shadow copy of the memory and checks both ports against it
`timescale 1ns/1ps

module tdpBramArrayTb
  import bramArrayPkg::*;
();

  localparam int ClkHalf      = 10;
  localparam int ClkPeriod    = 20;
  localparam int ResetCycles  = 3;
  localparam int AccessCycles = 2;
  localparam int HoldCycles   = 4;
  localparam int MarginCycles = 200;

  // Cycle budget of the test sequence below
  localparam int TestCycles = ResetCycles + 2
                            + NumSerBrams * 2 * AccessCycles
                            + NumSerBrams * 3 * AccessCycles
                            + 2 * AccessCycles + HoldCycles
                            + NumSerBrams * 2 * AccessCycles
                            + 4 * AccessCycles;

  logic                A_PS;
  logic                rst;
  logic                aEn;
  logic [AddrBitw-1:0] aAddr;
  logic [ArrBytew-1:0] aWrEn;
  logic [ArrBitw-1:0]  aWrData;
  logic [ArrBitw-1:0]  aRdData;
  logic                bEn;
  logic [AddrBitw-1:0] bAddr;
  logic [ArrBytew-1:0] bWrEn;
  logic [ArrBitw-1:0]  bWrData;
  logic [ArrBitw-1:0]  bRdData;

  int                  errors = 0;
  int                  seed   = 59;
  logic [ArrBitw-1:0]  shadow [NumArrWords];
  // Read data captured after the latest access
  logic [ArrBitw-1:0]  aGot;
  logic [ArrBitw-1:0]  bGot;

  tdpBramArray tdpBramArray_inst (
    .A_PS    (A_PS),
    .rst     (rst),
    .aEn     (aEn),
    .aAddr   (aAddr),
    .aWrEn   (aWrEn),
    .aWrData (aWrData),
    .aRdData (aRdData),
    .bEn     (bEn),
    .bAddr   (bAddr),
    .bWrEn   (bWrEn),
    .bWrData (bWrData),
    .bRdData (bRdData)
  );

  always #ClkHalf A_PS = ~A_PS;

  // Row in the upper bits, word index below it
  function automatic logic [WordAddrBitw-1:0] wordNum(input logic [SerIdxBitw-1:0] row,
                                                      input logic [WordIdxBitw-1:0] word);
    return {row, word};
  endfunction

  function automatic logic [AddrBitw-1:0] byteAddr(input logic [SerIdxBitw-1:0] row,
                                                   input logic [WordIdxBitw-1:0] word);
    return AddrBitw'(wordNum(row, word)) << AddrWordBito;
  endfunction

  function automatic logic [ArrBitw-1:0] mergeBytes(input logic [ArrBitw-1:0] oldWord,
                                                    input logic [ArrBitw-1:0] newWord,
                                                    input logic [ArrBytew-1:0] mask);
    logic [ArrBitw-1:0] result;
    result = oldWord;
    for (int i = 0; i < ArrBytew; i++) begin
      if (mask[i]) begin
        result[i*8 +: 8] = newWord[i*8 +: 8];
      end
    end
    return result;
  endfunction

  function automatic logic [ArrBitw-1:0] randWord();
    return {$random(seed), $random(seed), $random(seed)};
  endfunction

  function automatic logic [WordIdxBitw-1:0] randWordIdx();
    return WordIdxBitw'($random(seed));
  endfunction

  task automatic checkWord(input string testName, input logic [ArrBitw-1:0] expected,
                           input logic [ArrBitw-1:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s expected %h actual %h", testName, expected, actual);
    end
  endtask

  // One enabled cycle on both ports, then one idle cycle while the result is sampled
  task automatic access(input logic aE, input logic [AddrBitw-1:0] aA,
                        input logic [ArrBytew-1:0] aW, input logic [ArrBitw-1:0] aD,
                        input logic bE, input logic [AddrBitw-1:0] bA,
                        input logic [ArrBytew-1:0] bW, input logic [ArrBitw-1:0] bD);
    aEn     <= aE;
    aAddr   <= aA;
    aWrEn   <= aW;
    aWrData <= aD;
    bEn     <= bE;
    bAddr   <= bA;
    bWrEn   <= bW;
    bWrData <= bD;
    @(posedge A_PS);
    aEn   <= 1'b0;
    aWrEn <= '0;
    bEn   <= 1'b0;
    bWrEn <= '0;
    @(negedge A_PS);
    aGot = aRdData;
    bGot = bRdData;
    @(posedge A_PS);
  endtask

  task automatic testReset();
    @(negedge A_PS);
    checkWord("testReset", '0, aRdData);
    checkWord("testReset", '0, bRdData);
    @(posedge A_PS);
  endtask

  task automatic testWriteRead();
    logic [WordIdxBitw-1:0]  word;
    logic [WordAddrBitw-1:0] idx;
    logic [ArrBitw-1:0]      data;
    for (int r = 0; r < NumSerBrams; r++) begin
      word = randWordIdx();
      idx  = wordNum(SerIdxBitw'(r), word);
      data = randWord();
      shadow[idx] = data;
      access(1'b1, byteAddr(SerIdxBitw'(r), word), '1, data, 1'b0, '0, '0, '0);
      access(1'b0, '0, '0, '0, 1'b1, byteAddr(SerIdxBitw'(r), word), '0, '0);
      checkWord("testWriteRead", shadow[idx], bGot);
    end
  endtask

  task automatic testByteEnables();
    logic [WordIdxBitw-1:0]  word;
    logic [WordAddrBitw-1:0] idx;
    logic [ArrBitw-1:0]      data;
    logic [ArrBytew-1:0]     mask;
    for (int r = 0; r < NumSerBrams; r++) begin
      word = randWordIdx();
      idx  = wordNum(SerIdxBitw'(r), word);
      data = randWord();
      shadow[idx] = data;
      access(1'b0, '0, '0, '0, 1'b1, byteAddr(SerIdxBitw'(r), word), '1, data);
      // Partial write from the other port
      data = randWord();
      mask = ArrBytew'($random(seed));
      shadow[idx] = mergeBytes(shadow[idx], data, mask);
      access(1'b1, byteAddr(SerIdxBitw'(r), word), mask, data, 1'b0, '0, '0, '0);
      access(1'b0, '0, '0, '0, 1'b1, byteAddr(SerIdxBitw'(r), word), '0, '0);
      checkWord("testByteEnables", shadow[idx], bGot);
    end
  endtask

  task automatic testWriteFirst();
    logic [WordIdxBitw-1:0]  word;
    logic [WordAddrBitw-1:0] idx;
    logic [ArrBitw-1:0]      data;
    logic [ArrBytew-1:0]     mask;
    word = randWordIdx();
    idx  = wordNum(SerIdxBitw'(2), word);
    data = randWord();
    shadow[idx] = data;
    access(1'b1, byteAddr(SerIdxBitw'(2), word), '1, data, 1'b0, '0, '0, '0);
    checkWord("testWriteFirst", shadow[idx], aGot);
    data = randWord();
    mask = ArrBytew'($random(seed));
    shadow[idx] = mergeBytes(shadow[idx], data, mask);
    access(1'b1, byteAddr(SerIdxBitw'(2), word), mask, data, 1'b0, '0, '0, '0);
    checkWord("testWriteFirst", shadow[idx], aGot);
    // Port idle on another row and word, output must stay put
    aAddr <= byteAddr(SerIdxBitw'(1), ~word);
    repeat (HoldCycles) begin
      @(negedge A_PS);
      checkWord("testWriteFirst", shadow[idx], aRdData);
      @(posedge A_PS);
    end
  endtask

  task automatic testDualPort();
    logic [WordIdxBitw-1:0]  wordA;
    logic [WordIdxBitw-1:0]  wordB;
    logic [AddrBitw-1:0]     addrA;
    logic [AddrBitw-1:0]     addrB;
    logic [ArrBitw-1:0]      dataA;
    logic [ArrBitw-1:0]      dataB;
    for (int r = 0; r < NumSerBrams; r++) begin
      wordA = randWordIdx();
      wordB = randWordIdx();
      // Row of port B wraps around past the last row
      addrA = byteAddr(SerIdxBitw'(r), wordA);
      addrB = byteAddr(SerIdxBitw'(r + 1), wordB);
      dataA = randWord();
      dataB = randWord();
      shadow[wordNum(SerIdxBitw'(r), wordA)] = dataA;
      shadow[wordNum(SerIdxBitw'(r + 1), wordB)] = dataB;
      access(1'b1, addrA, '1, dataA, 1'b1, addrB, '1, dataB);
      checkWord("testDualPort", dataA, aGot);
      checkWord("testDualPort", dataB, bGot);
      access(1'b1, addrB, '0, '0, 1'b1, addrA, '0, '0);
      checkWord("testDualPort", dataB, aGot);
      checkWord("testDualPort", dataA, bGot);
    end
  endtask

  task automatic testOutOfRange();
    logic [WordIdxBitw-1:0]  word;
    logic [WordAddrBitw-1:0] idx;
    logic [AddrBitw-1:0]     oorAddr;
    logic [ArrBitw-1:0]      data;
    word = randWordIdx();
    idx  = wordNum(SerIdxBitw'(0), word);
    data = randWord();
    shadow[idx] = data;
    access(1'b1, byteAddr(SerIdxBitw'(0), word), '1, data, 1'b0, '0, '0, '0);
    // Row 3 in the word field, but one bit above it set as well
    oorAddr = byteAddr(SerIdxBitw'(3), word) | (AddrBitw'(1) << (AddrWordBito + WordAddrBitw));
    access(1'b1, oorAddr, '1, randWord(), 1'b0, '0, '0, '0);
    checkWord("testOutOfRange", shadow[idx], aGot);
    access(1'b0, '0, '0, '0, 1'b1, byteAddr(SerIdxBitw'(0), word), '0, '0);
    checkWord("testOutOfRange", shadow[idx], bGot);
    access(1'b0, '0, '0, '0, 1'b1, oorAddr, '0, '0);
    checkWord("testOutOfRange", shadow[idx], bGot);
  endtask

  initial begin
    #((TestCycles + MarginCycles) * ClkPeriod);
    $display("Timeout, tests did not finish within %0d cycles", TestCycles + MarginCycles);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    A_PS    = 1'b0;
    rst     = 1'b1;
    aEn     = 1'b0;
    aAddr   = '0;
    aWrEn   = '0;
    aWrData = '0;
    bEn     = 1'b0;
    bAddr   = '0;
    bWrEn   = '0;
    bWrData = '0;
    repeat (ResetCycles) @(posedge A_PS);
    rst <= 1'b0;

    testReset();
    testWriteRead();
    testByteEnables();
    testWriteFirst();
    testDualPort();
    testOutOfRange();

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: files.f
src/bramArrayPkg.sv
src/bramAddrDecode.sv
src/bramCell.sv
src/bramCellArray.sv
src/bramReadSelect.sv
src/tdpBramArray.sv
tb/tdpBramArrayTb.sv

// File: Makefile
# Verilator flow for the dual-port block-RAM array
# Any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= files.f
TOP       ?= tdpBramArrayTb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)

# Pass or fail is decided by the pass line in the log
sim: $(BUILD_DIR)/$(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
